/* mxint_pkg.sv */
// ------------------------------
// MXInt layer sizes, vector types
// and the accumulator state encoding
// ------------------------------

package mxint_pkg;

  // Block format
  localparam int MAN_W   = 8;
  localparam int EXP_W   = 8;
  localparam int BLOCK_N = 4;
  localparam int BLOCK_W = BLOCK_N * MAN_W + EXP_W;

  // Weight memory
  localparam int W_DEPTH = 16;
  localparam int W_AW    = 4;

  // Dot terms per result
  localparam int ACC_LEN = 4;

  // Arithmetic widths
  localparam int PROD_W     = 16;
  localparam int DOT_W      = 18;
  localparam int ACC_W      = 24;
  localparam int TERM_EXP_W = 9;

  // Mantissa and shared exponent of one block
  typedef logic signed [MAN_W-1:0] man_t;
  typedef logic signed [EXP_W-1:0] exp_t;

  // Sum of four products, and the exponent that goes with it
  typedef logic signed [DOT_W-1:0]      dot_t;
  typedef logic signed [TERM_EXP_W-1:0] texp_t;

  // Aligned running sum
  typedef logic signed [ACC_W-1:0] acc_t;

  // Mantissa j at [8j+15:8j+8], exponent at [7:0]
  typedef logic [BLOCK_W-1:0] block_bits_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    HOLD
  } acc_state_t;

endpackage

/* mxint_block_if.sv */
// ------------------------------
// One MXInt block with valid/ready,
// source and sink views
// ------------------------------

`timescale 1ns/1ps

interface mxint_block_if import mxint_pkg::*; ();

  // Block payload
  man_t mant [BLOCK_N];
  exp_t exp;

  // A block moves when both are high
  logic valid;
  logic ready;

  modport source (
    output mant,
    output exp,
    output valid,
    input  ready
  );

  modport sink (
    input  mant,
    input  exp,
    input  valid,
    output ready
  );

endinterface

/* act_block_in.sv */
// ------------------------------
// Activation input stage with a
// two-entry skid buffer
// ------------------------------

`timescale 1ns/1ps

module act_block_in import mxint_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [BLOCK_N*MAN_W-1:0] in_mant,
  input  exp_t                     in_exp,
  input  logic                     in_valid,
  output logic                     in_ready,
  mxint_block_if.source            blk
);

  block_bits_t in_bits;
  block_bits_t out_bits;
  block_bits_t skid_bits;
  logic        out_valid;
  logic        skid_valid;
  logic        in_fire;
  logic        out_free;

  // Lane j of in_mant lands above the exponent
  assign in_bits  = {in_mant, in_exp};

  // Ready comes from a register, not from blk.ready
  assign in_ready = !skid_valid;
  assign in_fire  = in_valid && in_ready;
  assign out_free = !out_valid || blk.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      // Skid entry is older, so it drains first
      if (skid_valid) begin
        out_bits <= skid_bits;
      end else if (in_fire) begin
        out_bits <= in_bits;
      end
    end
    if (!out_free && in_fire) begin
      skid_bits <= in_bits;
    end
  end

  for (genvar j = 0; j < BLOCK_N; j++) begin : g_lane
    assign blk.mant[j] = out_bits[MAN_W*j+EXP_W +: MAN_W];
  end
  assign blk.exp   = out_bits[EXP_W-1:0];
  assign blk.valid = out_valid;

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !blk.ready |=> out_valid && $stable(out_bits))
    else $error("activation block changed while stalled");

endmodule

/* weight_rom.sv */
// ------------------------------
// Weight ROM, two registered
// read stages with clock enable
// ------------------------------

`timescale 1ns/1ps

module weight_rom import mxint_pkg::*; (
  input  logic            clk,
  input  logic [W_AW-1:0] addr,
  input  logic            ce,
  output block_bits_t     q
);

  block_bits_t mem [0:W_DEPTH-1];
  block_bits_t q_t0;
  block_bits_t q_t1;

  initial begin
    $readmemh("weights.mem", mem);
  end

  // Array read stage
  always_ff @(posedge clk) begin
    if (ce) begin
      q_t0 <= mem[addr];
    end
  end

  // Output register
  always_ff @(posedge clk) begin
    if (ce) begin
      q_t1 <= q_t0;
    end
  end

  assign q = q_t1;

endmodule

/* weight_source.sv */
// ------------------------------
// Cyclic weight block stream from
// the ROM onto a block interface
// ------------------------------

`timescale 1ns/1ps

module weight_source import mxint_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  mxint_block_if.source blk
);

  // One bit wider than the ROM address
  logic [W_AW:0] addr_cnt;
  logic [1:0]    fill_cnt;
  logic          ce;
  logic          wgt_valid;
  block_bits_t   rom_q;

  // Both ROM stages hold full once fill_cnt reaches 2
  assign wgt_valid = (fill_cnt == 2'd2);

  // Advance when the output stage is empty or leaving
  assign ce = !wgt_valid || blk.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_cnt <= '0;
    end else if (ce) begin
      if (addr_cnt == (W_AW+1)'(W_DEPTH - 1)) begin
        addr_cnt <= '0;
      end else begin
        addr_cnt <= addr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_cnt <= 2'd0;
    end else if (ce && fill_cnt != 2'd2) begin
      fill_cnt <= fill_cnt + 2'd1;
    end
  end

  weight_rom i_weight_rom (
    .clk  (clk),
    .addr (addr_cnt[W_AW-1:0]),
    .ce   (ce),
    .q    (rom_q)
  );

  // Unpack ROM word into lanes
  for (genvar j = 0; j < BLOCK_N; j++) begin : g_lane
    assign blk.mant[j] = rom_q[MAN_W*j+EXP_W +: MAN_W];
  end
  assign blk.exp   = rom_q[EXP_W-1:0];
  assign blk.valid = wgt_valid;

  a_addr_range: assert property (@(posedge clk) disable iff (rst)
    addr_cnt <= (W_AW+1)'(W_DEPTH - 1))
    else $error("weight address out of range");

endmodule

/* block_dot.sv */
// ------------------------------
// Pairs activation and weight
// blocks, two-stage dot product
// ------------------------------

`timescale 1ns/1ps

module block_dot import mxint_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  mxint_block_if.sink act,
  mxint_block_if.sink wgt,
  output dot_t        term_dot,
  output texp_t       term_exp,
  output logic        term_valid,
  input  logic        term_ready
);

  logic signed [PROD_W-1:0] s1_prod [BLOCK_N];
  texp_t                    s1_exp;
  logic                     s1_valid;
  dot_t                     s2_dot;
  texp_t                    s2_exp;
  logic                     s2_valid;
  dot_t                     prod_sum;
  logic                     advance;
  logic                     fire;

  // Whole pipe moves as one
  assign advance = !s2_valid || term_ready;
  assign fire    = advance && act.valid && wgt.valid;

  assign act.ready = fire;
  assign wgt.ready = fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= fire;
      s2_valid <= s1_valid;
    end
  end

  // Stage 1 registers the products and the exponent sum
  always_ff @(posedge clk) begin
    if (fire) begin
      for (int j = 0; j < BLOCK_N; j++) begin
        s1_prod[j] <= act.mant[j] * wgt.mant[j];
      end
      s1_exp <= {act.exp[EXP_W-1], act.exp} + {wgt.exp[EXP_W-1], wgt.exp};
    end
  end

  always_comb begin
    prod_sum = '0;
    for (int j = 0; j < BLOCK_N; j++) begin
      prod_sum = prod_sum + s1_prod[j];
    end
  end

  // Stage 2 registers the sum of products
  always_ff @(posedge clk) begin
    if (advance && s1_valid) begin
      s2_dot <= prod_sum;
      s2_exp <= s1_exp;
    end
  end

  assign term_dot   = s2_dot;
  assign term_exp   = s2_exp;
  assign term_valid = s2_valid;

endmodule

/* block_accumulate.sv */
// ------------------------------
// Align-and-add of ACC_LEN dot
// terms, result held for out_ready
// ------------------------------

`timescale 1ns/1ps

module block_accumulate import mxint_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  dot_t  term_dot,
  input  texp_t term_exp,
  input  logic  term_valid,
  output logic  term_ready,
  output acc_t  out_mant,
  output texp_t out_exp,
  output logic  out_valid,
  input  logic  out_ready
);

  acc_state_t                 state;
  logic [$clog2(ACC_LEN)-1:0] term_cnt;
  acc_t                       acc_mant;
  texp_t                      acc_exp;
  acc_t                       term_ext;
  acc_t                       big_mant;
  acc_t                       small_mant;
  acc_t                       small_shifted;
  acc_t                       sum_mant;
  texp_t                      big_exp;
  texp_t                      small_exp;
  logic [TERM_EXP_W:0]        exp_diff;
  logic                       term_fire;

  assign term_ext   = acc_t'(term_dot);
  assign term_ready = (state != HOLD);
  assign term_fire  = term_valid && term_ready;
  assign out_valid  = (state == HOLD);

  // Larger exponent wins, ties keep the running sum
  always_comb begin
    if (term_exp > acc_exp) begin
      big_exp    = term_exp;
      big_mant   = term_ext;
      small_exp  = acc_exp;
      small_mant = acc_mant;
    end else begin
      big_exp    = acc_exp;
      big_mant   = acc_mant;
      small_exp  = term_exp;
      small_mant = term_ext;
    end
    // Always non-negative, one extra bit for the full range
    exp_diff = {big_exp[TERM_EXP_W-1], big_exp} - {small_exp[TERM_EXP_W-1], small_exp};
    if (exp_diff >= ACC_W) begin
      small_shifted = {ACC_W{small_mant[ACC_W-1]}};
    end else begin
      small_shifted = small_mant >>> exp_diff;
    end
    sum_mant = big_mant + small_shifted;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      term_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (term_fire) begin
            state    <= ACCUM;
            term_cnt <= term_cnt + 1'b1;
          end
        end
        ACCUM: begin
          if (term_fire) begin
            if (term_cnt == ACC_LEN - 1) begin
              state    <= HOLD;
              term_cnt <= '0;
            end else begin
              term_cnt <= term_cnt + 1'b1;
            end
          end
        end
        HOLD: begin
          if (out_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // First term of a group loads, the rest align and add
  always_ff @(posedge clk) begin
    if (term_fire) begin
      if (state == IDLE) begin
        acc_mant <= term_ext;
        acc_exp  <= term_exp;
      end else begin
        acc_mant <= sum_mant;
        acc_exp  <= big_exp;
      end
    end
  end

  assign out_mant = acc_mant;
  assign out_exp  = acc_exp;

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_mant) && $stable(out_exp))
    else $error("result dropped or changed without handshake");

endmodule

/* mxint_linear.sv */
// ------------------------------
// MXInt dot-product layer top,
// block instances and wiring
// ------------------------------

`timescale 1ns/1ps

module mxint_linear import mxint_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [BLOCK_N*MAN_W-1:0] in_mant,
  input  exp_t                     in_exp,
  input  logic                     in_valid,
  output logic                     in_ready,
  output acc_t                     out_mant,
  output texp_t                    out_exp,
  output logic                     out_valid,
  input  logic                     out_ready
);

  dot_t  term_dot;
  texp_t term_exp;
  logic  term_valid;
  logic  term_ready;

  mxint_block_if act_if ();
  mxint_block_if wgt_if ();

  act_block_in i_act_block_in (
    .clk      (clk),
    .rst      (rst),
    .in_mant  (in_mant),
    .in_exp   (in_exp),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .blk      (act_if.source)
  );

  weight_source i_weight_source (
    .clk (clk),
    .rst (rst),
    .blk (wgt_if.source)
  );

  block_dot i_block_dot (
    .clk        (clk),
    .rst        (rst),
    .act        (act_if.sink),
    .wgt        (wgt_if.sink),
    .term_dot   (term_dot),
    .term_exp   (term_exp),
    .term_valid (term_valid),
    .term_ready (term_ready)
  );

  block_accumulate i_block_accumulate (
    .clk        (clk),
    .rst        (rst),
    .term_dot   (term_dot),
    .term_exp   (term_exp),
    .term_valid (term_valid),
    .term_ready (term_ready),
    .out_mant   (out_mant),
    .out_exp    (out_exp),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

/* tb_mxint_model.svh */
// ------------------------------
// Reference model of the layer:
// weight table, dot term and
// align-accumulate of a group
// ------------------------------

`ifndef TB_MXINT_MODEL_SVH
`define TB_MXINT_MODEL_SVH

// Weight rows as stored in the memory file
logic [39:0] w_table [0:15];

task automatic load_weight_table();
  $readmemh("weights.mem", w_table);
endtask

// Signed mantissa j of a packed block
function automatic int block_mant(input logic [39:0] blk, input int j);
  logic signed [7:0] m;
  m = blk[8*j+8 +: 8];
  return int'(m);
endfunction

function automatic int block_exp(input logic [39:0] blk);
  logic signed [7:0] e;
  e = blk[7:0];
  return int'(e);
endfunction

// Exact sum of the four mantissa products
function automatic int dot_mant(input logic [39:0] act, input logic [39:0] wgt);
  int sum;
  sum = 0;
  for (int j = 0; j < 4; j++) begin
    sum += block_mant(act, j) * block_mant(wgt, j);
  end
  return sum;
endfunction

function automatic int dot_exp(input logic [39:0] act, input logic [39:0] wgt);
  return block_exp(act) + block_exp(wgt);
endfunction

// Keep the larger exponent, shift the other operand right
function automatic void align_add(inout int acc_m, inout int acc_e,
                                  input int t_m, input int t_e);
  int big_m;
  int small_m;
  int gap;
  if (t_e > acc_e) begin
    big_m   = t_m;
    small_m = acc_m;
    gap     = t_e - acc_e;
    acc_e   = t_e;
  end else begin
    big_m   = acc_m;
    small_m = t_m;
    gap     = acc_e - t_e;
  end
  // Gap of 24 or more leaves only the sign
  if (gap >= 24) begin
    small_m = (small_m < 0) ? -1 : 0;
  end else begin
    small_m = small_m >>> gap;
  end
  acc_m = big_m + small_m;
endfunction

`endif

/* tb_mxint_linear.sv */
// ------------------------------
// Testbench for the MXInt layer:
// random blocks and stalls, model
// checker and watchdog
// ------------------------------

`timescale 1ns/1ps

module tb_mxint_linear import mxint_pkg::*; ();

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 16;
  localparam int NUM_BLOCKS     = 200;
  localparam int NUM_RESULTS    = NUM_BLOCKS / ACC_LEN;
  localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 40;

  logic                     clk;
  logic                     rst;
  logic [BLOCK_N*MAN_W-1:0] in_mant;
  exp_t                     in_exp;
  logic                     in_valid;
  logic                     in_ready;
  acc_t                     out_mant;
  texp_t                    out_exp;
  logic                     out_valid;
  logic                     out_ready;

  // Model state
  int    accepted;
  int    results;
  int    acc_m;
  int    acc_e;
  int    exp_mant_q [$];
  int    exp_exp_q [$];

  // Handshake bookkeeping
  logic  in_pending;
  logic  stalled;
  logic  saw_in_ready_low;
  acc_t  held_mant;
  texp_t held_exp;

  `include "tb_mxint_model.svh"

  mxint_linear i_mxint_linear (
    .clk       (clk),
    .rst       (rst),
    .in_mant   (in_mant),
    .in_exp    (in_exp),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_mant  (out_mant),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: results still missing after %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  // Extreme values in the first group, exponent gaps 0, 3, 30 in the second
  task automatic make_act_block(input int k, output logic [BLOCK_N*MAN_W-1:0] m,
                                output exp_t e);
    m = $urandom();
    e = exp_t'(int'($urandom_range(12, 0)) - 6);
    case (k)
      0: begin
        m = 32'h8080_8080;
        e = 8'h7f;
      end
      1: begin
        m = 32'h8080_8080;
        e = 8'h80;
      end
      2: begin
        m = 32'h7f7f_7f7f;
        e = 8'h00;
      end
      3: begin
        m = 32'hffff_ffff;
        e = 8'h05;
      end
      4: e = exp_t'(-3);
      5: e = exp_t'(1);
      6: e = exp_t'(-1);
      7: begin
        m = 32'h0000_0064;
        e = exp_t'(-25);
      end
      default: ;
    endcase
  endtask

  // Pair the accepted block with the next weight row
  task automatic model_accept();
    logic [BLOCK_W-1:0] act_bits;
    int                 t_m;
    int                 t_e;
    act_bits = {in_mant, in_exp};
    t_m = dot_mant(act_bits, w_table[accepted % W_DEPTH]);
    t_e = dot_exp(act_bits, w_table[accepted % W_DEPTH]);
    if (accepted % ACC_LEN == 0) begin
      acc_m = t_m;
      acc_e = t_e;
    end else begin
      align_add(acc_m, acc_e, t_m, t_e);
    end
    if (accepted % ACC_LEN == ACC_LEN - 1) begin
      exp_mant_q.push_back(acc_m);
      exp_exp_q.push_back(acc_e);
    end
    accepted++;
  endtask

  task automatic check_result();
    acc_t  want_mant;
    texp_t want_exp;
    assert (exp_mant_q.size() > 0)
      else stop_on_error("A result arrived with no expected value left");
    want_mant = acc_t'(exp_mant_q.pop_front());
    want_exp  = texp_t'(exp_exp_q.pop_front());
    assert (out_mant == want_mant)
      else stop_on_error($sformatf("MISMATCH out_mant: got 0x%h expected 0x%h (result %0d)",
                                   out_mant, want_mant, results));
    assert (out_exp == want_exp)
      else stop_on_error($sformatf("MISMATCH out_exp: got 0x%h expected 0x%h (result %0d)",
                                   out_exp, want_exp, results));
  endtask

  // Result must stay put while out_ready is low
  task automatic check_hold();
    assert (out_valid)
      else stop_on_error("out_valid dropped while out_ready was low");
    assert (out_mant == held_mant)
      else stop_on_error($sformatf("MISMATCH out_mant: got 0x%h expected 0x%h during stall",
                                   out_mant, held_mant));
    assert (out_exp == held_exp)
      else stop_on_error($sformatf("MISMATCH out_exp: got 0x%h expected 0x%h during stall",
                                   out_exp, held_exp));
  endtask

  initial begin
    void'($urandom(62));
    load_weight_table();
    rst              = 1'b1;
    in_mant          = '0;
    in_exp           = '0;
    in_valid         = 1'b0;
    out_ready        = 1'b0;
    accepted         = 0;
    results          = 0;
    in_pending       = 1'b0;
    stalled          = 1'b0;
    saw_in_ready_low = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!out_valid)
      else stop_on_error("out_valid was high at the end of reset");

    // Outputs are registered, so they are settled at the falling edge
    while (results < NUM_RESULTS) begin
      @(negedge clk);
      if (stalled) begin
        check_hold();
      end
      assert (!(out_valid && accepted < ACC_LEN))
        else stop_on_error("out_valid rose before four blocks were accepted");
      if (!in_ready) begin
        saw_in_ready_low = 1'b1;
      end
      // An offered block stays on the port until taken
      if (!in_pending) begin
        if (accepted < NUM_BLOCKS && $urandom_range(99, 0) < 70) begin
          make_act_block(accepted, in_mant, in_exp);
          in_valid = 1'b1;
        end else begin
          in_valid = 1'b0;
        end
      end
      out_ready = ($urandom_range(99, 0) < 60);
      // Transfers at the coming rising edge
      if (in_valid && in_ready) begin
        model_accept();
      end
      in_pending = in_valid && !in_ready;
      if (out_valid && out_ready) begin
        check_result();
        results++;
      end
      stalled   = out_valid && !out_ready;
      held_mant = out_mant;
      held_exp  = out_exp;
    end

    out_ready = 1'b1;
    repeat (20) begin
      @(negedge clk);
      assert (!out_valid)
        else stop_on_error("An extra result appeared after the last expected one");
    end
    assert (accepted == NUM_BLOCKS && exp_mant_q.size() == 0)
      else stop_on_error($sformatf("Count wrong: %0d blocks taken, %0d results never seen",
                                   accepted, exp_mant_q.size()));
    assert (saw_in_ready_low)
      else stop_on_error("in_ready never dropped, back-pressure was not exercised");
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* weights.mem */
// Sixteen weight blocks, one per line, 40 bits in hex
// Columns: mant3 mant2 mant1 mant0 exp, one signed byte each
8080808000
7f7f7f7f01
fffefdfc02
01020304fd
12ee34cc03
817e05fbff
40c020e004
0af6649cfe
3344556600
d52b11ef05
7f8001fffa
0810f0f802
60a03cc401
e7197b85fc
0505050507
aa55cc33f9

/* mxint_linear.f */
+incdir+.
mxint_pkg.sv
mxint_block_if.sv
act_block_in.sv
weight_rom.sv
weight_source.sv
block_dot.sv
block_accumulate.sv
mxint_linear.sv
tb_mxint_linear.sv
